// File: all.f
soc_pkg.sv
dev_bus_if.sv
bus_decoder.sv
data_ram.sv
gpio_regs.sv
pwm_bank.sv
periph_system.sv
periph_checker.sv
tb_periph_system.sv

// File: bus_decoder.sv
////////////////////////////////////////
// Wishbone classic slave and address decoder.
// Runs one device access at a time.
////////////////////////////////////////
`timescale 1ns/1ps

module bus_decoder (
  input  logic               clk_sys_i,
  input  logic               rst_n_i,

  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  soc_pkg::bus_addr_t wb_adr_i,
  input  soc_pkg::bus_be_t   wb_sel_i,
  input  soc_pkg::bus_data_t wb_dat_i,
  output soc_pkg::bus_data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,

  dev_bus_if.host            ram_o,
  dev_bus_if.host            gpio_o,
  dev_bus_if.host            pwm_o
);

  logic               busy_q;
  logic               err_q;
  logic               accept;
  logic               sel_ram;
  logic               sel_gpio;
  logic               sel_pwm;
  logic               mapped;
  soc_pkg::bus_addr_t base_addr;
  soc_pkg::dev_addr_t dev_offset;

  // Window base and local offset.
  assign base_addr  = wb_adr_i & ~soc_pkg::DevMask;
  assign dev_offset = wb_adr_i[soc_pkg::DevAddrWidth-1:0];

  assign sel_ram  = (base_addr == soc_pkg::RamBase);
  assign sel_gpio = (base_addr == soc_pkg::GpioBase);
  assign sel_pwm  = (base_addr == soc_pkg::PwmBase);
  assign mapped   = sel_ram | sel_gpio | sel_pwm;

  assign accept = wb_cyc_i & wb_stb_i & ~busy_q;

  ////////////////////////////////////////
  // Device requests.
  ////////////////////////////////////////

  assign ram_o.req   = accept & sel_ram;
  assign ram_o.we    = wb_we_i;
  assign ram_o.addr  = dev_offset;
  assign ram_o.be    = wb_sel_i;
  assign ram_o.wdata = wb_dat_i;

  assign gpio_o.req   = accept & sel_gpio;
  assign gpio_o.we    = wb_we_i;
  assign gpio_o.addr  = dev_offset;
  assign gpio_o.be    = wb_sel_i;
  assign gpio_o.wdata = wb_dat_i;

  assign pwm_o.req   = accept & sel_pwm;
  assign pwm_o.we    = wb_we_i;
  assign pwm_o.addr  = dev_offset;
  assign pwm_o.be    = wb_sel_i;
  assign pwm_o.wdata = wb_dat_i;

  ////////////////////////////////////////
  // Response path.
  ////////////////////////////////////////

  // Only the addressed device answers.
  assign wb_ack_o = ram_o.rvalid | gpio_o.rvalid | pwm_o.rvalid;
  assign wb_err_o = err_q;

  always_comb begin
    wb_dat_o = '0;
    if (ram_o.rvalid) begin
      wb_dat_o = ram_o.rdata;
    end else if (gpio_o.rvalid) begin
      wb_dat_o = gpio_o.rdata;
    end else if (pwm_o.rvalid) begin
      wb_dat_o = pwm_o.rdata;
    end
  end

  // Busy from acceptance until ack or err.
  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      err_q <= accept & ~mapped;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (wb_ack_o || err_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // At most one request or answer in flight.
  onehot_req_a: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $onehot0({ram_o.req, gpio_o.req, pwm_o.req,
              ram_o.rvalid, gpio_o.rvalid, pwm_o.rvalid}));

  // A device answer and a decode error never coincide.
  ack_err_excl_a: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    !(wb_ack_o && wb_err_o));

endmodule

// File: data_ram.sv
////////////////////////////////////////
// Data RAM with byte-enabled writes.
////////////////////////////////////////
`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned RamDepth = 256
) (
  input logic       clk_sys_i,
  input logic       rst_n_i,
  dev_bus_if.device bus_i
);

  localparam int unsigned IdxWidth = $clog2(RamDepth);

  soc_pkg::bus_data_t                 mem [RamDepth];
  logic [soc_pkg::DevAddrWidth-3:0]   word_idx;
  logic [IdxWidth-1:0]                ram_idx;

  // Word address from the byte offset.
  assign word_idx = bus_i.addr[soc_pkg::DevAddrWidth-1:2];
  assign ram_idx  = word_idx[IdxWidth-1:0];

  // Write lanes and read word.
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int lane = 0; lane < soc_pkg::BusByteEnable; lane++) begin
          if (bus_i.be[lane]) begin
            mem[ram_idx][lane*8 +: 8] <= bus_i.wdata[lane*8 +: 8];
          end
        end
      end
      bus_i.rdata <= mem[ram_idx];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  // The decoder window is larger than the RAM.
  idx_range_a: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    bus_i.req |-> (word_idx < RamDepth));

endmodule

// File: dev_bus_if.sv
////////////////////////////////////////
// Device register bus.
// One request per access, answered one cycle later.
////////////////////////////////////////
`timescale 1ns/1ps

interface dev_bus_if;

  // Request side, driven by the decoder.
  logic               req;
  logic               we;
  soc_pkg::dev_addr_t addr;
  soc_pkg::bus_be_t   be;
  soc_pkg::bus_data_t wdata;

  // Response side, driven by the device.
  logic               rvalid;
  soc_pkg::bus_data_t rdata;

  modport host (
    output req,
    output we,
    output addr,
    output be,
    output wdata,
    input  rvalid,
    input  rdata
  );

  modport device (
    input  req,
    input  we,
    input  addr,
    input  be,
    input  wdata,
    output rvalid,
    output rdata
  );

endinterface

// File: gpio_regs.sv
////////////////////////////////////////
// GPIO output register and input readback.
////////////////////////////////////////
`timescale 1ns/1ps

module gpio_regs #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,
  dev_bus_if.device           bus_i,
  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);

  logic [GpoWidth-1:0] gpo_q;
  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  logic                out_wr;

  assign out_wr = bus_i.req & bus_i.we & (bus_i.addr == soc_pkg::GpioOutOffset);
  assign gp_o   = gpo_q;

  // Output register, one byte lane per enable.
  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpo_q <= '0;
    end else if (out_wr) begin
      for (int b = 0; b < GpoWidth; b++) begin
        if (bus_i.be[b / 8]) begin
          gpo_q[b] <= bus_i.wdata[b];
        end
      end
    end
  end

  // Two-flop input synchronizer.
  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  // Readback. Unknown offsets read zero.
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      case (bus_i.addr)
        soc_pkg::GpioOutOffset: bus_i.rdata <= soc_pkg::bus_data_t'(gpo_q);
        soc_pkg::GpioInOffset:  bus_i.rdata <= soc_pkg::bus_data_t'(gpi_sync_q);
        default:                bus_i.rdata <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  // Answer comes next cycle with no new request on top of it.
  rvalid_lat_a: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    bus_i.req |=> (bus_i.rvalid && !bus_i.req));

endmodule

// File: periph_checker.sv
////////////////////////////////////////
// Peripheral subsystem checker.
// Models RAM, GPIO and PWM state from the bus.
////////////////////////////////////////
`timescale 1ns/1ps

module periph_checker #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24,
  parameter int unsigned PwmWidth = 12
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  soc_pkg::bus_addr_t  adr_i,
  input  soc_pkg::bus_be_t    sel_i,
  input  soc_pkg::bus_data_t  wdata_i,
  input  soc_pkg::bus_data_t  rdata_i,
  input  logic                ack_i,
  input  logic                err_i,
  input  logic [GpiWidth-1:0] gp_in_i,
  input  logic [GpoWidth-1:0] gp_out_i,
  input  logic [PwmWidth-1:0] pwm_i,
  input  logic                exp_err_i,
  output int                  error_count_o,
  output int                  check_count_o,
  output logic                meas_busy_o
);

  soc_pkg::bus_data_t  ram_model [int];
  logic [GpoWidth-1:0] gpo_model;
  logic [15:0]         pwm_model [PwmWidth];
  logic                gpo_pending = 1'b0;
  logic                measuring = 1'b0;
  int                  meas_chan = 0;
  int                  skip_left = 0;
  int                  win_left = 0;
  int                  high_cnt = 0;
  int                  exp_high = 0;
  int                  errors = 0;
  int                  checks = 0;
  int                  reset_cycles = 0;
  int                  run_cycles = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_quiet(input string when);
    checks++;
    if (ack_i !== 1'b0 || err_i !== 1'b0 || gp_out_i !== '0 || pwm_i !== '0) begin
      flag_mismatch($sformatf("outputs not all low %s", when));
    end
  endtask

  ////////////////////////////////////////
  // Model updates and read comparison.
  ////////////////////////////////////////

  task automatic apply_write(input soc_pkg::bus_addr_t base, input int unsigned off);
    soc_pkg::bus_data_t word;
    int unsigned        ch;
    int                 p;
    int                 d;
    ch = off / 4;
    if (base == soc_pkg::RamBase) begin
      word = ram_model.exists(int'(ch)) ? ram_model[int'(ch)] : 'x;
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          word[b*8 +: 8] = wdata_i[b*8 +: 8];
        end
      end
      ram_model[int'(ch)] = word;
    end else if (base == soc_pkg::GpioBase && off == soc_pkg::GpioOutOffset) begin
      for (int i = 0; i < GpoWidth; i++) begin
        if (sel_i[i / 8]) begin
          gpo_model[i] = wdata_i[i];
        end
      end
      gpo_pending = 1'b1;
    end else if (base == soc_pkg::PwmBase && ch < PwmWidth) begin
      if (sel_i[0]) pwm_model[ch][7:0] = wdata_i[7:0];
      if (sel_i[1]) pwm_model[ch][15:8] = wdata_i[15:8];
      // Period p gives p+1 clocks, duty is capped there.
      p = int'(pwm_model[ch][15:8]);
      d = int'(pwm_model[ch][7:0]);
      meas_chan = int'(ch);
      skip_left = p + 1;
      win_left  = p + 1;
      high_cnt  = 0;
      exp_high  = (d < p + 1) ? d : p + 1;
      measuring = 1'b1;
    end
  endtask

  task automatic check_read(input soc_pkg::bus_addr_t base, input int unsigned off);
    soc_pkg::bus_data_t exp;
    int unsigned        ch;
    ch  = off / 4;
    exp = '0;
    if (base == soc_pkg::RamBase && !ram_model.exists(int'(ch))) begin
      flag_failure($sformatf("RAM word at %h was read before any write", adr_i));
    end else begin
      if (base == soc_pkg::RamBase) begin
        exp = ram_model[int'(ch)];
      end else if (base == soc_pkg::GpioBase && off == soc_pkg::GpioOutOffset) begin
        exp = soc_pkg::bus_data_t'(gpo_model);
      end else if (base == soc_pkg::GpioBase && off == soc_pkg::GpioInOffset) begin
        exp = soc_pkg::bus_data_t'(gp_in_i);
      end else if (base == soc_pkg::PwmBase && ch < PwmWidth) begin
        exp = soc_pkg::bus_data_t'(pwm_model[ch]);
      end
      if (rdata_i !== exp) begin
        flag_mismatch($sformatf("read %h returned %h, expected %h", adr_i, rdata_i, exp));
      end
    end
  endtask

  // Skip one full period, then count high clocks over one period.
  task automatic step_measure();
    if (measuring && skip_left > 0) begin
      skip_left--;
    end else if (measuring) begin
      if (pwm_i[meas_chan]) high_cnt++;
      win_left--;
      if (win_left == 0) begin
        measuring = 1'b0;
        checks++;
        if (high_cnt != exp_high) begin
          flag_mismatch($sformatf("PWM channel %0d high for %0d clocks, expected %0d",
                                  meas_chan, high_cnt, exp_high));
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    soc_pkg::bus_addr_t base;
    int unsigned        off;
    base = adr_i & ~soc_pkg::DevMask;
    off  = int'(adr_i[soc_pkg::DevAddrWidth-1:0]);
    if (!rst_n_i) begin
      reset_cycles++;
      run_cycles = 0;
      gpo_model  = '0;
      measuring  = 1'b0;
      for (int i = 0; i < PwmWidth; i++) begin
        pwm_model[i] = '0;
      end
      if (reset_cycles > 1) check_quiet("during reset");
    end else begin
      if (run_cycles < 2) check_quiet("right after reset");
      run_cycles++;
      step_measure();
      if (gpo_pending && gp_out_i !== gpo_model) begin
        flag_mismatch($sformatf("gp_o is %h, expected %h", gp_out_i, gpo_model));
      end
      gpo_pending = 1'b0;
      if (ack_i && err_i) flag_failure("ack and err were high in the same cycle");
      if ((ack_i || err_i) && !(cyc_i && stb_i)) flag_failure("response came without a request");
      if (ack_i || err_i) begin
        checks++;
        if (err_i !== exp_err_i) begin
          flag_mismatch($sformatf("err is %b for address %h, expected %b",
                                  err_i, adr_i, exp_err_i));
        end
        if (ack_i && we_i) begin
          apply_write(base, off);
        end else if (ack_i) begin
          check_read(base, off);
        end
      end
    end
    meas_busy_o <= measuring;
  end

endmodule

// File: periph_system.sv
////////////////////////////////////////
// Peripheral subsystem top level.
// Wishbone slave port to RAM, GPIO and PWM.
////////////////////////////////////////
`timescale 1ns/1ps

module periph_system #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24,
  parameter int unsigned PwmWidth = 12
) (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,

  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  soc_pkg::bus_addr_t  wb_adr_i,
  input  soc_pkg::bus_be_t    wb_sel_i,
  input  soc_pkg::bus_data_t  wb_dat_i,
  output soc_pkg::bus_data_t  wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic [PwmWidth-1:0] pwm_o
);

  // 1 KiB of data RAM.
  localparam int unsigned RamDepth = 256;

  dev_bus_if ram_bus ();
  dev_bus_if gpio_bus ();
  dev_bus_if pwm_bus ();

  bus_decoder u_decoder (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .ram_o    (ram_bus),
    .gpio_o   (gpio_bus),
    .pwm_o    (pwm_bus)
  );

  data_ram #(
    .RamDepth(RamDepth)
  ) u_ram (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus_i    (ram_bus)
  );

  gpio_regs #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus_i    (gpio_bus),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm_bank #(
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(soc_pkg::PwmCtrSize)
  ) u_pwm (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus_i    (pwm_bus),
    .pwm_o    (pwm_o)
  );

endmodule

// File: pwm_bank.sv
////////////////////////////////////////
// PWM channel bank.
// Per channel duty/period register and counter.
////////////////////////////////////////
`timescale 1ns/1ps

module pwm_bank #(
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,
  dev_bus_if.device           bus_i,
  output logic [PwmWidth-1:0] pwm_o
);

  localparam int unsigned ChanIdxWidth = soc_pkg::DevAddrWidth - 2;

  logic [PwmCtrSize-1:0]   duty_q   [PwmWidth];
  logic [PwmCtrSize-1:0]   period_q [PwmWidth];
  logic [PwmCtrSize-1:0]   ctr_q    [PwmWidth];
  logic [ChanIdxWidth-1:0] chan_idx;
  soc_pkg::bus_data_t      rd_word;

  // One register per word.
  assign chan_idx = bus_i.addr[soc_pkg::DevAddrWidth-1:2];

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    logic wr_en;

    assign wr_en = bus_i.req & bus_i.we & (chan_idx == ChanIdxWidth'(i));

    // Lane 0 holds duty, lane 1 period. A write restarts the counter.
    always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        duty_q[i]   <= '0;
        period_q[i] <= '0;
        ctr_q[i]    <= '0;
      end else if (wr_en) begin
        if (bus_i.be[0]) begin
          duty_q[i] <= bus_i.wdata[PwmCtrSize-1:0];
        end
        if (bus_i.be[1]) begin
          period_q[i] <= bus_i.wdata[2*PwmCtrSize-1:PwmCtrSize];
        end
        ctr_q[i] <= '0;
      end else if (ctr_q[i] == period_q[i]) begin
        ctr_q[i] <= '0;
      end else begin
        ctr_q[i] <= ctr_q[i] + 1'b1;
      end
    end

    // High while below duty.
    assign pwm_o[i] = (ctr_q[i] < duty_q[i]);

    ctr_bound_a: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
      ctr_q[i] <= period_q[i]);
  end

  always_comb begin
    rd_word = '0;
    for (int i = 0; i < PwmWidth; i++) begin
      if (chan_idx == ChanIdxWidth'(i)) begin
        rd_word = soc_pkg::bus_data_t'({period_q[i], duty_q[i]});
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= rd_word;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_system -f all.f
./obj_dir/Vtb_periph_system | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "Simulation failed."
  exit 1
fi
echo "Simulation finished without failure."

// File: soc_pkg.sv
////////////////////////////////////////
// Peripheral subsystem definitions.
// Bus widths, address map and register layout.
////////////////////////////////////////
package soc_pkg;

  ////////////////////////////////////////
  // Bus widths and types.
  ////////////////////////////////////////

  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusByteEnable = 4;
  localparam int unsigned DevAddrWidth  = 12;

  typedef logic [BusDataWidth-1:0]  bus_data_t;
  typedef logic [BusAddrWidth-1:0]  bus_addr_t;
  typedef logic [BusByteEnable-1:0] bus_be_t;
  typedef logic [DevAddrWidth-1:0]  dev_addr_t;

  ////////////////////////////////////////
  // Address map.
  ////////////////////////////////////////

  localparam bus_addr_t RamBase  = 32'h0000_0000;
  localparam bus_addr_t GpioBase = 32'h8000_0000;
  localparam bus_addr_t PwmBase  = 32'h8000_1000;

  // Each device owns a 4 KiB window.
  localparam bus_addr_t DevMask  = 32'h0000_0FFF;

  ////////////////////////////////////////
  // Register layout.
  ////////////////////////////////////////

  localparam dev_addr_t GpioOutOffset = 12'h000;
  localparam dev_addr_t GpioInOffset  = 12'h004;

  // PWM counter width, duty in 7:0 and period in 15:8.
  localparam int unsigned PwmCtrSize = 8;

endpackage

// File: tb_periph_system.sv
////////////////////////////////////////
// Peripheral subsystem testbench.
// Wishbone accesses from a table, checked by the watcher.
////////////////////////////////////////
`timescale 1ns/1ps

module tb_periph_system;

  localparam int unsigned GpiWidth = 13;
  localparam int unsigned GpoWidth = 24;
  localparam int unsigned PwmWidth = 12;
  localparam int unsigned NumAcc   = 26;
  localparam int          Timeout  = 1000;

  typedef struct packed {
    logic               we;
    soc_pkg::bus_addr_t adr;
    soc_pkg::bus_be_t   sel;
    soc_pkg::bus_data_t dat;
    logic               rnd;
    logic               exp_err;
  } access_t;

  // Write flag, address, byte enables, data, random data, error expected.
  localparam access_t AccTable [NumAcc] = '{
    '{1'b1, 32'h0000_0000, 4'hf, 32'hdead_beef, 1'b0, 1'b0},
    '{1'b1, 32'h0000_0004, 4'hf, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b1, 32'h0000_03fc, 4'hf, 32'h0123_4567, 1'b0, 1'b0},
    '{1'b0, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, 32'h0000_0000, 4'h5, 32'ha5a5_a5a5, 1'b0, 1'b0},
    '{1'b0, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, 32'h0000_0004, 4'h8, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 32'h0000_0004, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, 32'h0000_03fc, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    // GPIO output and input.
    '{1'b1, 32'h8000_0000, 4'hf, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 32'h8000_0000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, 32'h8000_0000, 4'h2, 32'h0000_5a00, 1'b0, 1'b0},
    '{1'b0, 32'h8000_0000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, 32'h8000_0004, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    // PWM channels 0, 2 and 11.
    '{1'b1, 32'h8000_1000, 4'h3, 32'h0000_0903, 1'b0, 1'b0},
    '{1'b0, 32'h8000_1000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, 32'h8000_1008, 4'h3, 32'h0000_0500, 1'b0, 1'b0},
    '{1'b1, 32'h8000_102c, 4'h3, 32'h0000_0408, 1'b0, 1'b0},
    '{1'b0, 32'h8000_102c, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    // Unmapped, then state readback.
    '{1'b1, 32'h4000_0000, 4'hf, 32'hffff_ffff, 1'b0, 1'b1},
    '{1'b1, 32'h8000_2000, 4'hf, 32'h0000_0000, 1'b1, 1'b1},
    '{1'b0, 32'hc000_0010, 4'hf, 32'h0000_0000, 1'b0, 1'b1},
    '{1'b0, 32'h0000_0000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, 32'h8000_0000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, 32'h8000_1000, 4'hf, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, 32'h8000_0004, 4'hf, 32'h0000_0000, 1'b0, 1'b0}
  };

  logic                clk_sys;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  soc_pkg::bus_addr_t  wb_adr;
  soc_pkg::bus_be_t    wb_sel;
  soc_pkg::bus_data_t  wb_dat_w;
  soc_pkg::bus_data_t  wb_dat_r;
  logic                wb_ack;
  logic                wb_err;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic [PwmWidth-1:0] pwm;
  logic                exp_err;
  logic                meas_busy;
  int                  error_count;
  int                  check_count;
  logic [31:0]         lfsr_q;
  logic                timed_out;

  periph_system #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth),
    .PwmWidth(PwmWidth)
  ) periph_system_i (
    .clk_sys_i(clk_sys),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_sel_i (wb_sel),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err),
    .gp_i     (gp_in),
    .gp_o     (gp_out),
    .pwm_o    (pwm)
  );

  periph_checker #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth),
    .PwmWidth(PwmWidth)
  ) checker_i (
    .clk_i        (clk_sys),
    .rst_n_i      (rst_n),
    .cyc_i        (wb_cyc),
    .stb_i        (wb_stb),
    .we_i         (wb_we),
    .adr_i        (wb_adr),
    .sel_i        (wb_sel),
    .wdata_i      (wb_dat_w),
    .rdata_i      (wb_dat_r),
    .ack_i        (wb_ack),
    .err_i        (wb_err),
    .gp_in_i      (gp_in),
    .gp_out_i     (gp_out),
    .pwm_i        (pwm),
    .exp_err_i    (exp_err),
    .error_count_o(error_count),
    .check_count_o(check_count),
    .meas_busy_o  (meas_busy)
  );

  ////////////////////////////////////////
  // Random bits and bus driver.
  ////////////////////////////////////////

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = galois_step(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic wait_measure(input int idx, output logic to);
    int cycles;
    cycles = 0;
    @(posedge clk_sys);
    while (meas_busy && cycles < Timeout) begin
      @(posedge clk_sys);
      cycles++;
    end
    to = meas_busy;
    if (to) $display("ERROR: PWM measurement before access %0d never finished", idx);
  endtask

  task automatic run_access(input int idx, input access_t acc, output logic to);
    logic [31:0] data;
    logic        done;
    int          cycles;
    data = acc.dat;
    if (acc.rnd) take_bits(32, data);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= acc.we;
    wb_adr   <= acc.adr;
    wb_sel   <= acc.sel;
    wb_dat_w <= data;
    exp_err  <= acc.exp_err;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < Timeout) begin
      @(posedge clk_sys);
      done = wb_ack | wb_err;
      cycles++;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    to = !done;
    if (to) $display("ERROR: access %0d to address %h got neither ack nor err", idx, acc.adr);
  endtask

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  initial begin
    logic [31:0] gp_word;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_sel    = '0;
    wb_dat_w  = '0;
    gp_in     = '0;
    exp_err   = 1'b0;
    lfsr_q    = 32'h85c5_5063;
    timed_out = 1'b0;
    repeat (8) @(posedge clk_sys);
    rst_n <= 1'b1;
    for (int i = 0; i < NumAcc && !timed_out; i++) begin
      wait_measure(i, timed_out);
      if (!timed_out) begin
        // New inputs settle through the synchronizer first.
        take_bits(GpiWidth, gp_word);
        gp_in <= gp_word[GpiWidth-1:0];
        repeat (3) @(posedge clk_sys);
        run_access(i, AccTable[i], timed_out);
      end
    end
    if (!timed_out) wait_measure(NumAcc, timed_out);
    $display("Summary: %0d checks, %0d errors, timeout %0d", check_count, error_count,
             timed_out);
    if (timed_out || error_count != 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  end

endmodule
